//--- src.f
+incdir+hw
hw/secure_island_pkg.sv
hw/rst_sync.sv
hw/axil_upsizer.sv
hw/cdc_fifo_src_half.sv
hw/cdc_fifo_dst_half.sv
hw/axil_cdc_src.sv
hw/entropy_rng.sv
hw/secure_island_wrap.sv
tests/async_axil_mem.sv
tests/tb_secure_island.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator; run from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_secure_island \
   -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "Build failed, see build.log"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
   echo "Simulation exited with an error, see sim.log"
   exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed, see sim.log"
   exit 1
fi

//--- tests/tb_secure_island.sv
// Directed testbench for the island outbound path with a remote memory model
// Inputs change on the falling clk_i edge; outputs are read just after it
`include "secure_island_params.svh"

module tb_secure_island
   import secure_island_pkg::*;
;

   localparam int NumTests = 6;
   localparam logic [31:0] DataTaps = 32'h8020_0003;

   logic clk_i = 1'b0, clk_remote = 1'b0, arst_n_i;
   logic s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o, s_bvalid_o, s_bready_i;
   logic s_arvalid_i, s_arready_o, s_rvalid_o, s_rready_i;
   logic [`SI_ADDR_W-1:0] s_awaddr_i, s_araddr_i;
   logic [`SI_NARROW_DW-1:0] s_wdata_i, s_rdata_o;
   logic [`SI_NARROW_DW/8-1:0] s_wstrb_i;
   axil_resp_e s_bresp_o, s_rresp_o;
   logic [`SI_CDC_DEPTH*`SI_AW_W-1:0] async_aw_data_o;
   logic [`SI_CDC_DEPTH*`SI_W_W-1:0] async_w_data_o;
   logic [`SI_CDC_DEPTH*`SI_B_W-1:0] async_b_data_i;
   logic [`SI_CDC_DEPTH*`SI_AR_W-1:0] async_ar_data_o;
   logic [`SI_CDC_DEPTH*`SI_R_W-1:0] async_r_data_i;
   logic [CdcPtrW-1:0] async_aw_wptr_o, async_aw_rptr_i, async_w_wptr_o, async_w_rptr_i;
   logic [CdcPtrW-1:0] async_b_wptr_i, async_b_rptr_o, async_ar_wptr_o, async_ar_rptr_i;
   logic [CdcPtrW-1:0] async_r_wptr_i, async_r_rptr_o;
   logic rng_en_i, rng_valid_o;
   logic [3:0] rng_bits_o;

   logic [31:0] data_lfsr = 32'd47;
   int errors = 0, tests_failed = 0, test_start_errors = 0;

   always #10 clk_i = ~clk_i;
   always #17 clk_remote = ~clk_remote;

   secure_island_wrap UUT (.*);

   async_axil_mem u_mem (
      .clk_i(clk_remote), .arst_n_i,
      .aw_data_i(async_aw_data_o), .aw_wptr_i(async_aw_wptr_o), .aw_rptr_o(async_aw_rptr_i),
      .w_data_i(async_w_data_o), .w_wptr_i(async_w_wptr_o), .w_rptr_o(async_w_rptr_i),
      .b_data_o(async_b_data_i), .b_wptr_o(async_b_wptr_i), .b_rptr_i(async_b_rptr_o),
      .ar_data_i(async_ar_data_o), .ar_wptr_i(async_ar_wptr_o), .ar_rptr_o(async_ar_rptr_i),
      .r_data_o(async_r_data_i), .r_wptr_o(async_r_wptr_i), .r_rptr_i(async_r_rptr_o)
   );

   initial begin
      #(NumTests * 2000);
      $display("Watchdog expired before the tests completed");
      $display("TB FAILED");
      $finish;
   end

   // One LFSR step per bit taken
   function automatic logic [31:0] lfsr_bits(int n);
      logic [31:0] result;
      result = '0;
      for (int i = 0; i < n; i++) begin
         result = {result[30:0], data_lfsr[0]};
         data_lfsr = (data_lfsr >> 1) ^ (data_lfsr[0] ? DataTaps : 32'h0);
      end
      return result;
   endfunction

   task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
      assert (exp === act) else begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic report_test(string name);
      if (errors == test_start_errors) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - test_start_errors);
         tests_failed++;
      end
      test_start_errors = errors;
   endtask

   task automatic axil_write(logic [31:0] addr, logic [31:0] data, logic [3:0] strb,
                             output logic [1:0] resp);
      @(negedge clk_i);
      s_awvalid_i = 1'b1;
      s_wvalid_i  = 1'b1;
      s_awaddr_i  = addr;
      s_wdata_i   = data;
      s_wstrb_i   = strb;
      #1;
      while (!(s_awready_o && s_wready_o)) begin
         @(negedge clk_i);
         #1;
      end
      @(negedge clk_i);
      s_awvalid_i = 1'b0;
      s_wvalid_i  = 1'b0;
      s_bready_i  = 1'b1;
      #1;
      while (!s_bvalid_o) begin
         @(negedge clk_i);
         #1;
      end
      resp = s_bresp_o;
      @(negedge clk_i);
      s_bready_i = 1'b0;
   endtask

   task automatic ar_issue(logic [31:0] addr);
      @(negedge clk_i);
      s_arvalid_i = 1'b1;
      s_araddr_i  = addr;
      #1;
      while (!s_arready_o) begin
         @(negedge clk_i);
         #1;
      end
      @(negedge clk_i);
      s_arvalid_i = 1'b0;
   endtask

   task automatic r_collect(output logic [31:0] data, output logic [1:0] resp);
      @(negedge clk_i);
      s_rready_i = 1'b1;
      #1;
      while (!s_rvalid_o) begin
         @(negedge clk_i);
         #1;
      end
      data = s_rdata_o;
      resp = s_rresp_o;
      @(negedge clk_i);
      s_rready_i = 1'b0;
   endtask

   task automatic test_reset_state();
      check_value("reset awready", 64'(0), 64'(s_awready_o));
      check_value("reset bvalid", 64'(0), 64'(s_bvalid_o));
      check_value("reset rvalid", 64'(0), 64'(s_rvalid_o));
      check_value("reset rng_valid", 64'(0), 64'(rng_valid_o));
      check_value("reset wptrs", 64'(0), 64'({async_aw_wptr_o, async_w_wptr_o,
                  async_ar_wptr_o, async_b_wptr_i, async_r_wptr_i}));
      // Withdraw the offered traffic before the synchronized reset releases
      @(negedge clk_i);
      s_awvalid_i = 1'b0;
      s_wvalid_i  = 1'b0;
      rng_en_i    = 1'b0;
      report_test("reset_state");
   endtask

   task automatic test_lane_steering(output logic [31:0] lo, output logic [31:0] hi);
      logic [1:0]  resp;
      logic [31:0] rd;
      lo = lfsr_bits(32);
      hi = lfsr_bits(32);
      axil_write(32'h100, lo, 4'hF, resp);
      check_value("lane write lo resp", 64'(RESP_OKAY), 64'(resp));
      axil_write(32'h104, hi, 4'hF, resp);
      check_value("lane write hi resp", 64'(RESP_OKAY), 64'(resp));
      ar_issue(32'h100);
      r_collect(rd, resp);
      check_value("lane read lo data", 64'(lo), 64'(rd));
      check_value("lane read lo resp", 64'(RESP_OKAY), 64'(resp));
      ar_issue(32'h104);
      r_collect(rd, resp);
      check_value("lane read hi data", 64'(hi), 64'(rd));
      check_value("lane read hi resp", 64'(RESP_OKAY), 64'(resp));
      report_test("lane_steering");
   endtask

   task automatic test_byte_strobe(output logic [31:0] merged);
      logic [1:0]  resp;
      logic [31:0] base, patch, rd;
      base  = lfsr_bits(32);
      patch = lfsr_bits(32);
      axil_write(32'h200, base, 4'hF, resp);
      axil_write(32'h200, patch, 4'h1, resp);
      merged = {base[31:8], patch[7:0]};
      ar_issue(32'h200);
      r_collect(rd, resp);
      check_value("strobe readback", 64'(merged), 64'(rd));
      report_test("byte_strobe");
   endtask

   task automatic test_error_response();
      logic [1:0] resp;
      axil_write(32'h1000, lfsr_bits(32), 4'hF, resp);
      check_value("error bresp", 64'(RESP_SLVERR), 64'(resp));
      report_test("error_response");
   endtask

   task automatic test_read_backpressure(logic [31:0] lo, logic [31:0] hi, logic [31:0] mid);
      logic [31:0] addrs [4];
      logic [31:0] exps [4];
      logic [31:0] rd;
      logic [1:0]  resp;
      addrs = '{32'h100, 32'h104, 32'h200, 32'h104};
      exps  = '{lo, hi, mid, hi};
      for (int i = 0; i < 4; i++) begin
         ar_issue(addrs[i]);
      end
      #1;
      check_value("backpressure arready", 64'(0), 64'(s_arready_o));
      for (int i = 0; i < 4; i++) begin
         r_collect(rd, resp);
         check_value($sformatf("backpressure read %0d", i), 64'(exps[i]), 64'(rd));
      end
      report_test("read_backpressure");
   endtask

   task automatic test_rng_stream();
      logic [15:0] model [4];
      logic [3:0]  exp;
      model = '{16'hACE1, 16'h1D2B, 16'h7F3C, 16'h5A55};
      @(negedge clk_i);
      rng_en_i = 1'b1;
      #1;
      check_value("rng valid before first step", 64'(0), 64'(rng_valid_o));
      for (int c = 0; c < 16; c++) begin
         @(negedge clk_i);
         #1;
         for (int k = 0; k < 4; k++) begin
            model[k] = (model[k] >> 1) ^ (model[k][0] ? 16'hB400 : 16'h0000);
            exp[k]   = model[k][0];
         end
         check_value($sformatf("rng valid %0d", c), 64'(1), 64'(rng_valid_o));
         check_value($sformatf("rng bits %0d", c), 64'(exp), 64'(rng_bits_o));
      end
      @(negedge clk_i);
      rng_en_i = 1'b0;
      report_test("rng_stream");
   endtask

   initial begin
      logic [31:0] lo, hi, mid;
      arst_n_i    = 1'b0;
      // A write and the RNG are offered while reset is held
      s_awvalid_i = 1'b1;
      s_wvalid_i  = 1'b1;
      s_bready_i  = 1'b0;
      s_arvalid_i = 1'b0;
      s_rready_i  = 1'b0;
      s_awaddr_i  = '0;
      s_araddr_i  = '0;
      s_wdata_i   = '0;
      s_wstrb_i   = '0;
      rng_en_i    = 1'b1;
      repeat (5) @(negedge clk_i);
      arst_n_i = 1'b1;
      #1;
      test_reset_state();
      repeat (4) @(negedge clk_i);
      test_lane_steering(lo, hi);
      test_byte_strobe(mid);
      test_error_response();
      test_read_backpressure(lo, hi, mid);
      test_rng_stream();
      $display("tests run %0d, tests failed %0d, errors %0d", NumTests, tests_failed, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

//--- tests/async_axil_mem.sv
// Remote-domain model of the crossing's far side, backed by a 64-bit memory
// Addresses at or above 0x1000 return SLVERR; 512 words below that
`include "secure_island_params.svh"

module async_axil_mem
   import secure_island_pkg::*;
(
   input  logic                              clk_i,
   input  logic                              arst_n_i,
   input  logic [`SI_CDC_DEPTH*`SI_AW_W-1:0] aw_data_i,
   input  logic [CdcPtrW-1:0]                aw_wptr_i,
   output logic [CdcPtrW-1:0]                aw_rptr_o,
   input  logic [`SI_CDC_DEPTH*`SI_W_W-1:0]  w_data_i,
   input  logic [CdcPtrW-1:0]                w_wptr_i,
   output logic [CdcPtrW-1:0]                w_rptr_o,
   output logic [`SI_CDC_DEPTH*`SI_B_W-1:0]  b_data_o,
   output logic [CdcPtrW-1:0]                b_wptr_o,
   input  logic [CdcPtrW-1:0]                b_rptr_i,
   input  logic [`SI_CDC_DEPTH*`SI_AR_W-1:0] ar_data_i,
   input  logic [CdcPtrW-1:0]                ar_wptr_i,
   output logic [CdcPtrW-1:0]                ar_rptr_o,
   output logic [`SI_CDC_DEPTH*`SI_R_W-1:0]  r_data_o,
   output logic [CdcPtrW-1:0]                r_wptr_o,
   input  logic [CdcPtrW-1:0]                r_rptr_i
);

   logic                    rst_n;
   logic                    aw_valid, w_valid, ar_valid, b_ready, r_ready;
   logic                    wr_fire, rd_fire;
   logic [`SI_ADDR_W-1:0]   aw_addr, ar_addr;
   logic [`SI_W_W-1:0]      w_payload;
   logic [`SI_WIDE_DW-1:0]  rd_data;
   axil_resp_e              wr_resp, rd_resp;
   logic [`SI_WIDE_DW-1:0]  mem [512];

   // Fill depends on the whole word index
   initial begin
      for (int i = 0; i < 512; i++) begin
         mem[i] = {32'(i) ^ 32'hA5A5_0000, ~32'(i)};
      end
   end

   rst_sync u_rst_sync (.clk_i, .arst_n_i, .rst_n_o(rst_n));

   assign wr_fire = aw_valid & w_valid & b_ready;
   assign rd_fire = ar_valid & r_ready;
   assign wr_resp = (aw_addr >= 32'h1000) ? RESP_SLVERR : RESP_OKAY;
   assign rd_resp = (ar_addr >= 32'h1000) ? RESP_SLVERR : RESP_OKAY;
   assign rd_data = (ar_addr >= 32'h1000) ? '0 : mem[ar_addr[11:3]];

   always @(posedge clk_i) begin
      if (wr_fire && aw_addr < 32'h1000) begin
         for (int b = 0; b < 8; b++) begin
            if (w_payload[b]) begin
               mem[aw_addr[11:3]][8*b +: 8] <= w_payload[8 + 8*b +: 8];
            end
         end
      end
   end

   cdc_fifo_dst_half #(.Width(cdc_chan_width(CHAN_AW))) u_aw (
      .clk_i, .rst_n_i(rst_n), .valid_o(aw_valid), .ready_i(wr_fire), .data_o(aw_addr),
      .async_data_i(aw_data_i), .async_wptr_i(aw_wptr_i), .async_rptr_o(aw_rptr_o)
   );

   cdc_fifo_dst_half #(.Width(cdc_chan_width(CHAN_W))) u_w (
      .clk_i, .rst_n_i(rst_n), .valid_o(w_valid), .ready_i(wr_fire), .data_o(w_payload),
      .async_data_i(w_data_i), .async_wptr_i(w_wptr_i), .async_rptr_o(w_rptr_o)
   );

   cdc_fifo_dst_half #(.Width(cdc_chan_width(CHAN_AR))) u_ar (
      .clk_i, .rst_n_i(rst_n), .valid_o(ar_valid), .ready_i(rd_fire), .data_o(ar_addr),
      .async_data_i(ar_data_i), .async_wptr_i(ar_wptr_i), .async_rptr_o(ar_rptr_o)
   );

   cdc_fifo_src_half #(.Width(cdc_chan_width(CHAN_B))) u_b (
      .clk_i, .rst_n_i(rst_n), .valid_i(wr_fire), .ready_o(b_ready), .data_i(wr_resp),
      .async_data_o(b_data_o), .async_wptr_o(b_wptr_o), .async_rptr_i(b_rptr_i)
   );

   cdc_fifo_src_half #(.Width(cdc_chan_width(CHAN_R))) u_r (
      .clk_i, .rst_n_i(rst_n), .valid_i(rd_fire), .ready_o(r_ready),
      .data_i({rd_data, rd_resp}),
      .async_data_o(r_data_o), .async_wptr_o(r_wptr_o), .async_rptr_i(r_rptr_i)
   );

endmodule

//--- hw/secure_island_wrap.sv
// Secure island outbound path: narrow AXI4-Lite in, async crossing out
// arst_n_i is synchronized here; AW and W must be offered together
// Each async channel carries 2 entries of storage and 2-bit gray pointers
`include "secure_island_params.svh"

module secure_island_wrap
   import secure_island_pkg::*;
(
   input  logic                              clk_i,
   input  logic                              arst_n_i,
   input  logic                              s_awvalid_i,
   output logic                              s_awready_o,
   input  logic [`SI_ADDR_W-1:0]             s_awaddr_i,
   input  logic                              s_wvalid_i,
   output logic                              s_wready_o,
   input  logic [`SI_NARROW_DW-1:0]          s_wdata_i,
   input  logic [`SI_NARROW_DW/8-1:0]        s_wstrb_i,
   output logic                              s_bvalid_o,
   input  logic                              s_bready_i,
   output axil_resp_e                        s_bresp_o,
   input  logic                              s_arvalid_i,
   output logic                              s_arready_o,
   input  logic [`SI_ADDR_W-1:0]             s_araddr_i,
   output logic                              s_rvalid_o,
   input  logic                              s_rready_i,
   output logic [`SI_NARROW_DW-1:0]          s_rdata_o,
   output axil_resp_e                        s_rresp_o,
   output logic [`SI_CDC_DEPTH*`SI_AW_W-1:0] async_aw_data_o,
   output logic [CdcPtrW-1:0]                async_aw_wptr_o,
   input  logic [CdcPtrW-1:0]                async_aw_rptr_i,
   output logic [`SI_CDC_DEPTH*`SI_W_W-1:0]  async_w_data_o,
   output logic [CdcPtrW-1:0]                async_w_wptr_o,
   input  logic [CdcPtrW-1:0]                async_w_rptr_i,
   input  logic [`SI_CDC_DEPTH*`SI_B_W-1:0]  async_b_data_i,
   input  logic [CdcPtrW-1:0]                async_b_wptr_i,
   output logic [CdcPtrW-1:0]                async_b_rptr_o,
   output logic [`SI_CDC_DEPTH*`SI_AR_W-1:0] async_ar_data_o,
   output logic [CdcPtrW-1:0]                async_ar_wptr_o,
   input  logic [CdcPtrW-1:0]                async_ar_rptr_i,
   input  logic [`SI_CDC_DEPTH*`SI_R_W-1:0]  async_r_data_i,
   input  logic [CdcPtrW-1:0]                async_r_wptr_i,
   output logic [CdcPtrW-1:0]                async_r_rptr_o,
   input  logic                              rng_en_i,
   output logic [3:0]                        rng_bits_o,
   output logic                              rng_valid_o
);

   logic                        rst_n;
   // Wide port between upsizer and crossing
   logic                        wide_awvalid, wide_awready, wide_wvalid, wide_wready;
   logic                        wide_bvalid, wide_bready, wide_arvalid, wide_arready;
   logic                        wide_rvalid, wide_rready;
   logic [`SI_ADDR_W-1:0]       wide_awaddr, wide_araddr;
   logic [`SI_WIDE_DW-1:0]      wide_wdata, wide_rdata;
   logic [`SI_WIDE_DW/8-1:0]    wide_wstrb;
   axil_resp_e                  wide_bresp, wide_rresp;

   rst_sync u_rst_sync (.clk_i, .arst_n_i, .rst_n_o(rst_n));

   axil_upsizer u_upsizer (
      .*, .rst_n_i(rst_n),
      .m_awvalid_o(wide_awvalid), .m_awready_i(wide_awready), .m_awaddr_o(wide_awaddr),
      .m_wvalid_o(wide_wvalid), .m_wready_i(wide_wready),
      .m_wdata_o(wide_wdata), .m_wstrb_o(wide_wstrb),
      .m_bvalid_i(wide_bvalid), .m_bready_o(wide_bready), .m_bresp_i(wide_bresp),
      .m_arvalid_o(wide_arvalid), .m_arready_i(wide_arready), .m_araddr_o(wide_araddr),
      .m_rvalid_i(wide_rvalid), .m_rready_o(wide_rready),
      .m_rdata_i(wide_rdata), .m_rresp_i(wide_rresp)
   );

   axil_cdc_src u_cdc (
      .*, .rst_n_i(rst_n),
      .s_awvalid_i(wide_awvalid), .s_awready_o(wide_awready), .s_awaddr_i(wide_awaddr),
      .s_wvalid_i(wide_wvalid), .s_wready_o(wide_wready),
      .s_wdata_i(wide_wdata), .s_wstrb_i(wide_wstrb),
      .s_bvalid_o(wide_bvalid), .s_bready_i(wide_bready), .s_bresp_o(wide_bresp),
      .s_arvalid_i(wide_arvalid), .s_arready_o(wide_arready), .s_araddr_i(wide_araddr),
      .s_rvalid_o(wide_rvalid), .s_rready_i(wide_rready),
      .s_rdata_o(wide_rdata), .s_rresp_o(wide_rresp)
   );

   entropy_rng u_rng (.*, .rst_n_i(rst_n));

endmodule

//--- hw/entropy_rng.sv
// Entropy stand-in from four Galois LFSRs, not a true random source
// Streams step on each enabled cycle; the first valid nibble is bit 0 of
// each stream after its first step, one cycle after enable

module entropy_rng (
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic       rng_en_i,
   output logic [3:0] rng_bits_o,
   output logic       rng_valid_o
);

   localparam int unsigned Streams = 4;
   localparam logic [15:0] Taps = 16'hB400;
   localparam logic [Streams-1:0][15:0] Seeds = {16'h5A55, 16'h7F3C, 16'h1D2B, 16'hACE1};

   logic [15:0] lfsr_q [Streams];
   logic        valid_q;

   for (genvar k = 0; k < Streams; k++) begin : g_stream
      always_ff @(posedge clk_i or negedge rst_n_i) begin
         if (!rst_n_i) begin
            lfsr_q[k] <= Seeds[k];
         end else if (rng_en_i) begin
            lfsr_q[k] <= (lfsr_q[k] >> 1) ^ (lfsr_q[k][0] ? Taps : 16'h0000);
         end
      end

      assign rng_bits_o[k] = lfsr_q[k][0];
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= rng_en_i;
      end
   end

   assign rng_valid_o = valid_q;

endmodule

//--- hw/axil_cdc_src.sv
// Source side of a five-channel AXI4-Lite crossing
// AW, W and AR are produced here; B and R storage lives in the remote domain
// Payloads: W is {data, strb}, R is {data, resp}
`include "secure_island_params.svh"

module axil_cdc_src
   import secure_island_pkg::*;
(
   input  logic                              clk_i,
   input  logic                              rst_n_i,
   input  logic                              s_awvalid_i,
   output logic                              s_awready_o,
   input  logic [`SI_ADDR_W-1:0]             s_awaddr_i,
   input  logic                              s_wvalid_i,
   output logic                              s_wready_o,
   input  logic [`SI_WIDE_DW-1:0]            s_wdata_i,
   input  logic [`SI_WIDE_DW/8-1:0]          s_wstrb_i,
   output logic                              s_bvalid_o,
   input  logic                              s_bready_i,
   output axil_resp_e                        s_bresp_o,
   input  logic                              s_arvalid_i,
   output logic                              s_arready_o,
   input  logic [`SI_ADDR_W-1:0]             s_araddr_i,
   output logic                              s_rvalid_o,
   input  logic                              s_rready_i,
   output logic [`SI_WIDE_DW-1:0]            s_rdata_o,
   output axil_resp_e                        s_rresp_o,
   output logic [`SI_CDC_DEPTH*`SI_AW_W-1:0] async_aw_data_o,
   output logic [CdcPtrW-1:0]                async_aw_wptr_o,
   input  logic [CdcPtrW-1:0]                async_aw_rptr_i,
   output logic [`SI_CDC_DEPTH*`SI_W_W-1:0]  async_w_data_o,
   output logic [CdcPtrW-1:0]                async_w_wptr_o,
   input  logic [CdcPtrW-1:0]                async_w_rptr_i,
   input  logic [`SI_CDC_DEPTH*`SI_B_W-1:0]  async_b_data_i,
   input  logic [CdcPtrW-1:0]                async_b_wptr_i,
   output logic [CdcPtrW-1:0]                async_b_rptr_o,
   output logic [`SI_CDC_DEPTH*`SI_AR_W-1:0] async_ar_data_o,
   output logic [CdcPtrW-1:0]                async_ar_wptr_o,
   input  logic [CdcPtrW-1:0]                async_ar_rptr_i,
   input  logic [`SI_CDC_DEPTH*`SI_R_W-1:0]  async_r_data_i,
   input  logic [CdcPtrW-1:0]                async_r_wptr_i,
   output logic [CdcPtrW-1:0]                async_r_rptr_o
);

   logic [`SI_B_W-1:0] b_data;
   logic [`SI_R_W-1:0] r_data;

   assign s_bresp_o = axil_resp_e'(b_data);
   assign s_rdata_o = r_data[`SI_R_W-1:`SI_B_W];
   assign s_rresp_o = axil_resp_e'(r_data[`SI_B_W-1:0]);

   cdc_fifo_src_half #(.Width(cdc_chan_width(CHAN_AW))) u_aw (
      .clk_i, .rst_n_i,
      .valid_i(s_awvalid_i), .ready_o(s_awready_o), .data_i(s_awaddr_i),
      .async_data_o(async_aw_data_o), .async_wptr_o(async_aw_wptr_o),
      .async_rptr_i(async_aw_rptr_i)
   );

   cdc_fifo_src_half #(.Width(cdc_chan_width(CHAN_W))) u_w (
      .clk_i, .rst_n_i,
      .valid_i(s_wvalid_i), .ready_o(s_wready_o), .data_i({s_wdata_i, s_wstrb_i}),
      .async_data_o(async_w_data_o), .async_wptr_o(async_w_wptr_o),
      .async_rptr_i(async_w_rptr_i)
   );

   cdc_fifo_dst_half #(.Width(cdc_chan_width(CHAN_B))) u_b (
      .clk_i, .rst_n_i,
      .valid_o(s_bvalid_o), .ready_i(s_bready_i), .data_o(b_data),
      .async_data_i(async_b_data_i), .async_wptr_i(async_b_wptr_i),
      .async_rptr_o(async_b_rptr_o)
   );

   cdc_fifo_src_half #(.Width(cdc_chan_width(CHAN_AR))) u_ar (
      .clk_i, .rst_n_i,
      .valid_i(s_arvalid_i), .ready_o(s_arready_o), .data_i(s_araddr_i),
      .async_data_o(async_ar_data_o), .async_wptr_o(async_ar_wptr_o),
      .async_rptr_i(async_ar_rptr_i)
   );

   cdc_fifo_dst_half #(.Width(cdc_chan_width(CHAN_R))) u_r (
      .clk_i, .rst_n_i,
      .valid_o(s_rvalid_o), .ready_i(s_rready_i), .data_o(r_data),
      .async_data_i(async_r_data_i), .async_wptr_i(async_r_wptr_i),
      .async_rptr_o(async_r_rptr_o)
   );

endmodule

//--- hw/cdc_fifo_dst_half.sv
// Read half of a gray-pointer async FIFO, reading storage held by the remote
// write half. Valid is registered, so an entry shows up a cycle after sync
`include "secure_island_params.svh"

module cdc_fifo_dst_half
   import secure_island_pkg::*;
#(
   parameter int unsigned Width = 32
) (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   output logic                           valid_o,
   input  logic                           ready_i,
   output logic [Width-1:0]               data_o,
   input  logic [`SI_CDC_DEPTH*Width-1:0] async_data_i,
   input  logic [CdcPtrW-1:0]             async_wptr_i,
   output logic [CdcPtrW-1:0]             async_rptr_o
);

   logic [CdcPtrW-1:0] rbin_q, rbin_d, rgray_q, rgray_d;
   logic [CdcPtrW-1:0] wptr_s1_q, wptr_s2_q;
   logic               pop, valid_q;

   assign pop     = valid_q & ready_i;
   assign rbin_d  = rbin_q + CdcPtrW'(pop);
   assign rgray_d = rbin_d ^ (rbin_d >> 1);
   assign data_o  = async_data_i[rbin_q[CdcPtrW-2:0]*Width +: Width];

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rbin_q    <= '0;
         rgray_q   <= '0;
         wptr_s1_q <= '0;
         wptr_s2_q <= '0;
         valid_q   <= 1'b0;
      end else begin
         rbin_q    <= rbin_d;
         rgray_q   <= rgray_d;
         wptr_s1_q <= async_wptr_i;
         wptr_s2_q <= wptr_s1_q;
         valid_q   <= (cdc_fill_state(wptr_s2_q, rgray_d) != CDC_EMPTY);
      end
   end

   assign valid_o      = valid_q;
   assign async_rptr_o = rgray_q;

endmodule

//--- hw/cdc_fifo_src_half.sv
// Write half of a gray-pointer async FIFO; it owns the storage, which the
// remote half reads directly once the synchronized write pointer covers it
// Ready is registered and sees the remote read pointer two flops late
`include "secure_island_params.svh"

module cdc_fifo_src_half
   import secure_island_pkg::*;
#(
   parameter int unsigned Width = 32
) (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  logic                           valid_i,
   output logic                           ready_o,
   input  logic [Width-1:0]               data_i,
   output logic [`SI_CDC_DEPTH*Width-1:0] async_data_o,
   output logic [CdcPtrW-1:0]             async_wptr_o,
   input  logic [CdcPtrW-1:0]             async_rptr_i
);

   logic [`SI_CDC_DEPTH-1:0][Width-1:0] mem_q;
   logic [CdcPtrW-1:0] wbin_q, wbin_d, wgray_q, wgray_d;
   logic [CdcPtrW-1:0] rptr_s1_q, rptr_s2_q;
   logic               push, ready_q;

   assign push    = valid_i & ready_q;
   assign wbin_d  = wbin_q + CdcPtrW'(push);
   assign wgray_d = wbin_d ^ (wbin_d >> 1);

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem_q[wbin_q[CdcPtrW-2:0]] <= data_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wbin_q    <= '0;
         wgray_q   <= '0;
         rptr_s1_q <= '0;
         rptr_s2_q <= '0;
         ready_q   <= 1'b0;
      end else begin
         wbin_q    <= wbin_d;
         wgray_q   <= wgray_d;
         rptr_s1_q <= async_rptr_i;
         rptr_s2_q <= rptr_s1_q;
         // Stale read pointer only underestimates free space
         ready_q   <= (cdc_fill_state(wgray_d, rptr_s2_q) != CDC_FULL);
      end
   end

   assign ready_o      = ready_q;
   assign async_data_o = mem_q;
   assign async_wptr_o = wgray_q;

endmodule

//--- hw/axil_upsizer.sv
// AXI4-Lite 32-to-64-bit upsizer, handshakes pass through with no added cycle
// AW and W are forwarded as a pair: a manager must raise both valids and
// hold them until both readies. Up to `SI_RD_LANE_DEPTH reads in flight
`include "secure_island_params.svh"

module axil_upsizer
   import secure_island_pkg::*;
(
   input  logic                         clk_i,
   input  logic                         rst_n_i,
   input  logic                         s_awvalid_i,
   output logic                         s_awready_o,
   input  logic [`SI_ADDR_W-1:0]        s_awaddr_i,
   input  logic                         s_wvalid_i,
   output logic                         s_wready_o,
   input  logic [`SI_NARROW_DW-1:0]     s_wdata_i,
   input  logic [`SI_NARROW_DW/8-1:0]   s_wstrb_i,
   output logic                         s_bvalid_o,
   input  logic                         s_bready_i,
   output axil_resp_e                   s_bresp_o,
   input  logic                         s_arvalid_i,
   output logic                         s_arready_o,
   input  logic [`SI_ADDR_W-1:0]        s_araddr_i,
   output logic                         s_rvalid_o,
   input  logic                         s_rready_i,
   output logic [`SI_NARROW_DW-1:0]     s_rdata_o,
   output axil_resp_e                   s_rresp_o,
   output logic                         m_awvalid_o,
   input  logic                         m_awready_i,
   output logic [`SI_ADDR_W-1:0]        m_awaddr_o,
   output logic                         m_wvalid_o,
   input  logic                         m_wready_i,
   output logic [`SI_WIDE_DW-1:0]       m_wdata_o,
   output logic [`SI_WIDE_DW/8-1:0]     m_wstrb_o,
   input  logic                         m_bvalid_i,
   output logic                         m_bready_o,
   input  axil_resp_e                   m_bresp_i,
   output logic                         m_arvalid_o,
   input  logic                         m_arready_i,
   output logic [`SI_ADDR_W-1:0]        m_araddr_o,
   input  logic                         m_rvalid_i,
   output logic                         m_rready_o,
   input  logic [`SI_WIDE_DW-1:0]       m_rdata_i,
   input  axil_resp_e                   m_rresp_i
);

   localparam int unsigned LaneDepth = `SI_RD_LANE_DEPTH;
   localparam int unsigned LanePtrW  = $clog2(LaneDepth);
   localparam int unsigned NarrowB   = `SI_NARROW_DW / 8;
   localparam int unsigned LaneBit   = $clog2(NarrowB);

   logic                 wr_both, wr_done, aw_ok, w_ok;
   logic                 aw_done_q, w_done_q;
   logic                 ar_push, r_pop, lane_full;
   logic                 lane_q [LaneDepth];
   logic [LanePtrW-1:0]  lane_wr_q, lane_rd_q;
   logic [LanePtrW:0]    lane_cnt_q;

   // Write pair fork, each side remembers if it already went
   assign wr_both     = s_awvalid_i & s_wvalid_i;
   assign aw_ok       = aw_done_q | m_awready_i;
   assign w_ok        = w_done_q | m_wready_i;
   assign wr_done     = wr_both & aw_ok & w_ok;
   assign m_awvalid_o = wr_both & ~aw_done_q;
   assign m_wvalid_o  = wr_both & ~w_done_q;
   assign s_awready_o = s_wvalid_i & aw_ok & w_ok;
   assign s_wready_o  = s_awvalid_i & aw_ok & w_ok;
   assign m_awaddr_o  = s_awaddr_i;
   assign m_wdata_o   = {2{s_wdata_i}};
   assign m_wstrb_o   = s_awaddr_i[LaneBit] ? {s_wstrb_i, {NarrowB{1'b0}}}
                                            : {{NarrowB{1'b0}}, s_wstrb_i};

   assign s_bvalid_o  = m_bvalid_i;
   assign m_bready_o  = s_bready_i;
   assign s_bresp_o   = m_bresp_i;

   assign lane_full   = (lane_cnt_q == LaneDepth);
   assign m_arvalid_o = s_arvalid_i & ~lane_full;
   assign s_arready_o = m_arready_i & ~lane_full;
   assign m_araddr_o  = s_araddr_i;
   assign ar_push     = s_arvalid_i & s_arready_o;

   assign s_rvalid_o  = m_rvalid_i;
   assign m_rready_o  = s_rready_i;
   assign r_pop       = m_rvalid_i & s_rready_i;
   assign s_rdata_o   = lane_q[lane_rd_q] ? m_rdata_i[`SI_WIDE_DW-1:`SI_NARROW_DW]
                                          : m_rdata_i[`SI_NARROW_DW-1:0];
   assign s_rresp_o   = m_rresp_i;

   always_ff @(posedge clk_i) begin
      if (ar_push) begin
         lane_q[lane_wr_q] <= s_araddr_i[LaneBit];
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         aw_done_q  <= 1'b0;
         w_done_q   <= 1'b0;
         lane_wr_q  <= '0;
         lane_rd_q  <= '0;
         lane_cnt_q <= '0;
      end else begin
         if (wr_done) begin
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
         end else begin
            aw_done_q <= aw_done_q | (m_awvalid_o & m_awready_i);
            w_done_q  <= w_done_q | (m_wvalid_o & m_wready_i);
         end
         lane_wr_q  <= lane_wr_q + LanePtrW'(ar_push);
         lane_rd_q  <= lane_rd_q + LanePtrW'(r_pop);
         lane_cnt_q <= lane_cnt_q + (LanePtrW + 1)'(ar_push) - (LanePtrW + 1)'(r_pop);
      end
   end

endmodule

//--- hw/rst_sync.sv
// Reset synchronizer: asserts at once, releases on the second clk_i edge
// after arst_n_i rises

module rst_sync (
   input  logic clk_i,
   input  logic arst_n_i,
   output logic rst_n_o
);

   logic [1:0] sync_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sync_q <= 2'b00;
      end else begin
         sync_q <= {sync_q[0], 1'b1};
      end
   end

   assign rst_n_o = sync_q[1];

endmodule

//--- hw/secure_island_pkg.sv
// Shared types of the island: AXI responses, crossing fill state, channel names
// Pointer helpers assume gray pointers one bit wider than the FIFO index
`include "secure_island_params.svh"

package secure_island_pkg;

   localparam int unsigned CdcPtrW = `SI_CDC_PTR_W;
   localparam logic [CdcPtrW-1:0] CdcFullMask = CdcPtrW'(3) << (CdcPtrW - 2);

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_EXOKAY = 2'b01,
      RESP_SLVERR = 2'b10,
      RESP_DECERR = 2'b11
   } axil_resp_e;

   typedef enum logic [1:0] {
      CDC_EMPTY,
      CDC_PARTIAL,
      CDC_FULL
   } cdc_fill_e;

   typedef enum logic [2:0] {
      CHAN_AW,
      CHAN_W,
      CHAN_B,
      CHAN_AR,
      CHAN_R
   } cdc_chan_e;

   function automatic int unsigned cdc_chan_width(cdc_chan_e chan);
      case (chan)
         CHAN_AW: return `SI_AW_W;
         CHAN_W:  return `SI_W_W;
         CHAN_B:  return `SI_B_W;
         CHAN_AR: return `SI_AR_W;
         default: return `SI_R_W;
      endcase
   endfunction

   // Full when only the top two gray bits differ
   function automatic cdc_fill_e cdc_fill_state(logic [CdcPtrW-1:0] wptr_g,
                                                logic [CdcPtrW-1:0] rptr_g);
      if (wptr_g == rptr_g) begin
         return CDC_EMPTY;
      end else if ((wptr_g ^ rptr_g) == CdcFullMask) begin
         return CDC_FULL;
      end
      return CDC_PARTIAL;
   endfunction

endpackage

//--- hw/secure_island_params.svh
// Widths and depths of the island outbound path
// The crossing depth is a power of two, at least 2; the lane FIFO depth too
// The narrow port is half the wide data width
`ifndef SECURE_ISLAND_PARAMS_SVH
`define SECURE_ISLAND_PARAMS_SVH

`define SI_ADDR_W         32
`define SI_NARROW_DW      32
`define SI_WIDE_DW        64
`define SI_CDC_LOG_DEPTH  1
`define SI_RD_LANE_DEPTH  4

`define SI_CDC_DEPTH      (1 << `SI_CDC_LOG_DEPTH)
`define SI_CDC_PTR_W      (`SI_CDC_LOG_DEPTH + 1)

// Channel payloads, data above strobe and data above response
`define SI_AW_W           `SI_ADDR_W
`define SI_W_W            (`SI_WIDE_DW + `SI_WIDE_DW / 8)
`define SI_B_W            2
`define SI_AR_W           `SI_ADDR_W
`define SI_R_W            (`SI_WIDE_DW + 2)

`endif
